/* nd_proc.f */
hdl/proc_pkg.sv
hdl/proc_cmd_dec.sv
hdl/proc_reg_file.sv
hdl/proc_idb_xcvr.sv
hdl/proc_alu_slice.sv
hdl/proc_sheet_top.sv
sim/clk_gen.sv
sim/tb_proc_sheet.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the processor sheet testbench with Verilator.
# Exit status is 0 only when the simulation log holds the pass message.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tb_proc_sheet \
  -f nd_proc.f -o tb_proc_sheet > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_proc_sheet > sim.log 2>&1
cat sim.log

grep -q "Testbench passed" sim.log \
  && { echo "Simulation PASS"; exit 0; } \
  || { echo "Simulation FAIL"; exit 1; }

/* sim/tb_proc_sheet.sv */
/*
  Processor sheet testbench
  Directed tests against a shadow register file and accumulator model
*/
module tb_proc_sheet;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DATA_W      = proc_pkg::data_w_default;
  localparam int CLK_NS      = 20;
  localparam int TEST_CYCLES = 4 + 1 + 1 + 40 + 6 + 10 + 4 + 8;  // Reset plus each test
  localparam int TIMEOUT_NS  = (TEST_CYCLES + 100) * CLK_NS;    // 100 cycles of margin

  logic              sysclk;
  logic              s_twrf_n;
  logic [63:0]       cs_bits;
  logic              wrfstb;
  logic              term_n;
  logic              estof_n;
  logic              bedo_n;
  logic [DATA_W-1:0] idb_in;
  logic [DATA_W-1:0] idb_out;
  logic              acond_n;
  logic              brk_n;
  logic [3:0]        pil;
  logic              lev0;

  // Bus controls applied together with the next microword
  logic              nx_wrfstb;
  logic              nx_term_n;
  logic              nx_estof_n;
  logic              nx_bedo_n;
  logic [DATA_W-1:0] nx_idb_in;

  logic [DATA_W-1:0] model_rf [0:1023];  // Shadow register file
  logic [DATA_W-1:0] model_acc;
  logic [31:0]       lcg_state = 32'h9b64;
  int                n_checks = 0;
  int                n_errors = 0;

  clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(4)) u_clk_gen (
    .sysclk   (sysclk),
    .s_twrf_n (s_twrf_n)
  );

  proc_sheet_top #(.DATA_W(DATA_W)) uut (
    .sysclk   (sysclk),
    .s_twrf_n (s_twrf_n),
    .cs_bits  (cs_bits),
    .wrfstb   (wrfstb),
    .term_n   (term_n),
    .estof_n  (estof_n),
    .bedo_n   (bedo_n),
    .idb_in   (idb_in),
    .idb_out  (idb_out),
    .acond_n  (acond_n),
    .brk_n    (brk_n),
    .pil      (pil),
    .lev0     (lev0)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes constants
    return lcg_state;
  endfunction

  // Microword from its fields, address split over rf, lba and laa
  function automatic logic [63:0] make_word(input proc_pkg::cscomm_e comm,
                                            input proc_pkg::csidbs_e idbs,
                                            input proc_pkg::alu_op_e op,
                                            input logic [proc_pkg::lit_w-1:0] lit,
                                            input logic [9:0] addr);
    logic [63:0] w;
    w = '0;
    w[proc_pkg::laa_lsb +: proc_pkg::laa_w]       = addr[3:0];
    w[proc_pkg::lba_lsb +: proc_pkg::lba_w]       = addr[7:4];
    w[proc_pkg::rf_lsb +: proc_pkg::rf_w]         = addr[9:8];
    w[proc_pkg::alu_op_lsb +: proc_pkg::alu_op_w] = op;
    w[proc_pkg::lit_lsb +: proc_pkg::lit_w]       = lit;
    w[proc_pkg::cscomm_lsb +: proc_pkg::cscomm_w] = comm;
    w[proc_pkg::csidbs_lsb +: proc_pkg::csidbs_w] = idbs;
    return w;
  endfunction

  // Reference ALU, A is the accumulator and B the bus
  function automatic logic [DATA_W-1:0] expected_alu(input proc_pkg::alu_op_e op,
                                                      input logic [DATA_W-1:0] a,
                                                      input logic [DATA_W-1:0] b);
    logic [DATA_W-1:0] r;
    case (op)
      proc_pkg::ALU_ADD:   r = a + b;
      proc_pkg::ALU_SUB:   r = a - b;
      proc_pkg::ALU_AND:   r = a & b;
      proc_pkg::ALU_OR:    r = a | b;
      proc_pkg::ALU_XOR:   r = a ^ b;
      proc_pkg::ALU_INC:   r = b + DATA_W'(1);
      proc_pkg::ALU_NOTB:  r = ~b;
      default:             r = b;  // PASSB
    endcase
    return r;
  endfunction

  // One microword per cycle, sampled at the falling edge
  task automatic step(input logic [63:0] word);
    @(posedge sysclk);
    cs_bits <= word;
    wrfstb  <= nx_wrfstb;
    term_n  <= nx_term_n;
    estof_n <= nx_estof_n;
    bedo_n  <= nx_bedo_n;
    idb_in  <= nx_idb_in;
    @(negedge sysclk);
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Fail %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_level(input string name, input logic [3:0] exp, input logic [3:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic read_reg(input string name, input logic [9:0] addr);
    nx_wrfstb  = 1'b0;
    nx_estof_n = 1'b1;  // Keep the transceiver off the bus
    step(make_word(proc_pkg::COMM_NOP, proc_pkg::IDBS_REG, proc_pkg::ALU_PASSB, '0, addr));
    check_data(name, model_rf[addr], idb_out);
  endtask

  task automatic write_lit(input logic [9:0] addr, input logic [DATA_W-1:0] lit);
    step(make_word(proc_pkg::COMM_WRTRF, proc_pkg::IDBS_LIT, proc_pkg::ALU_PASSB, lit, addr));
  endtask

  task automatic test_reset();
    step(make_word(proc_pkg::COMM_NOP, proc_pkg::IDBS_NONE, proc_pkg::ALU_PASSB, '0, '0));
    check_bit("reset brk_n", 1'b1, brk_n);
    check_level("reset pil", 4'h0, pil);
    check_bit("reset lev0", 1'b1, lev0);
    check_bit("reset acond_n", 1'b0, acond_n);  // Empty bus passed through
  endtask

  task automatic test_rf_write_read();
    logic [9:0]        addrs [0:19];
    logic [DATA_W-1:0] lit;
    logic [31:0]       r;
    nx_wrfstb = 1'b1;
    for (int i = 0; i < 20; i++) begin
      r        = next_rand();
      addrs[i] = r[31:22];
      r        = next_rand();
      lit      = r[31:16];
      write_lit(addrs[i], lit);
      model_rf[addrs[i]] = lit;  // Repeated address keeps the last word
    end
    for (int i = 0; i < 20; i++) begin
      read_reg($sformatf("rf_write_read %0d", i), addrs[i]);
    end
  endtask

  task automatic test_write_gating();
    logic [31:0] r;
    logic [9:0]  addr;
    r    = next_rand();
    addr = r[31:22];
    nx_wrfstb = 1'b1;
    write_lit(addr, 16'ha5c3);
    model_rf[addr] = 16'ha5c3;
    read_reg("gating baseline", addr);
    nx_wrfstb = 1'b0;  // Strobe missing
    write_lit(addr, 16'h0f0f);
    read_reg("gating wrfstb low", addr);
    nx_wrfstb = 1'b1;
    nx_term_n = 1'b0;  // Cycle not terminated
    write_lit(addr, 16'hf0f0);
    nx_term_n = 1'b1;
    read_reg("gating term_n low", addr);
  endtask

  task automatic test_alu_ops();
    proc_pkg::alu_op_e op;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] exp;
    logic [31:0]       r;
    r = next_rand();
    model_acc = r[31:16];
    step(make_word(proc_pkg::COMM_LDACC, proc_pkg::IDBS_LIT, proc_pkg::ALU_PASSB,
                   model_acc, '0));
    nx_estof_n = 1'b0;  // Result out on the external bus
    nx_bedo_n  = 1'b0;
    for (int k = 0; k < 9; k++) begin
      r = next_rand();
      b = r[31:16];
      if (k == 8) begin
        b = model_acc;  // Zero result through SUB
      end
      op  = proc_pkg::alu_op_e'(k % 8);
      op  = (k == 8) ? proc_pkg::ALU_SUB : op;
      exp = expected_alu(op, model_acc, b);
      step(make_word(proc_pkg::COMM_NOP, proc_pkg::IDBS_LIT, op, b, '0));
      check_data($sformatf("alu %s result", op.name()), exp, idb_out);
      check_bit($sformatf("alu %s acond_n", op.name()), exp != '0, acond_n);
    end
    nx_estof_n = 1'b1;
    nx_bedo_n  = 1'b1;
  endtask

  task automatic test_xcvr_in();
    logic [31:0] r;
    logic [9:0]  addr;
    r    = next_rand();
    addr = r[31:22];
    r    = next_rand();
    nx_idb_in  = r[31:16] | DATA_W'(1);  // Never zero
    nx_estof_n = 1'b0;
    nx_bedo_n  = 1'b1;  // Inbound direction
    nx_wrfstb  = 1'b1;
    step(make_word(proc_pkg::COMM_WRTRF, proc_pkg::IDBS_NONE, proc_pkg::ALU_PASSB, '0, addr));
    model_rf[addr] = nx_idb_in;
    read_reg("xcvr inbound", addr);
    nx_wrfstb = 1'b1;  // Transceiver now disabled, bus stays empty
    step(make_word(proc_pkg::COMM_WRTRF, proc_pkg::IDBS_NONE, proc_pkg::ALU_PASSB, '0, addr));
    model_rf[addr] = '0;
    read_reg("xcvr disabled", addr);
    nx_idb_in = '0;
  endtask

  task automatic test_pil_brk();
    step(make_word(proc_pkg::COMM_SETPIL, proc_pkg::IDBS_LIT, proc_pkg::ALU_PASSB, 16'h0005, '0));
    check_level("pil before edge", 4'h0, pil);
    step(make_word(proc_pkg::COMM_NOP, proc_pkg::IDBS_NONE, proc_pkg::ALU_PASSB, '0, '0));
    check_level("pil loaded", 4'h5, pil);
    check_bit("lev0 after setpil", 1'b0, lev0);
    step(make_word(proc_pkg::COMM_BRK, proc_pkg::IDBS_LIT, proc_pkg::ALU_PASSB, 16'h0004, '0));
    check_bit("brk_n same cycle", 1'b1, brk_n);
    step(make_word(proc_pkg::COMM_NOP, proc_pkg::IDBS_NONE, proc_pkg::ALU_PASSB, '0, '0));
    check_bit("brk_n taken", 1'b0, brk_n);
    step(make_word(proc_pkg::COMM_NOP, proc_pkg::IDBS_NONE, proc_pkg::ALU_PASSB, '0, '0));
    check_bit("brk_n released", 1'b1, brk_n);
    // Bit 2 clear, no break
    step(make_word(proc_pkg::COMM_BRK, proc_pkg::IDBS_LIT, proc_pkg::ALU_PASSB, 16'h0003, '0));
    step(make_word(proc_pkg::COMM_NOP, proc_pkg::IDBS_NONE, proc_pkg::ALU_PASSB, '0, '0));
    check_bit("brk_n not taken", 1'b1, brk_n);
    step(make_word(proc_pkg::COMM_NOP, proc_pkg::IDBS_NONE, proc_pkg::ALU_PASSB, '0, '0));
    check_bit("brk_n idle", 1'b1, brk_n);
  endtask

  initial begin
    cs_bits    = '0;
    wrfstb     = 1'b0;
    term_n     = 1'b1;
    estof_n    = 1'b1;
    bedo_n     = 1'b1;
    idb_in     = '0;
    nx_wrfstb  = 1'b0;
    nx_term_n  = 1'b1;
    nx_estof_n = 1'b1;
    nx_bedo_n  = 1'b1;
    nx_idb_in  = '0;
    model_acc  = '0;
    wait (s_twrf_n == 1'b1);
    test_reset();
    test_rf_write_read();
    test_write_gating();
    test_alu_ops();
    test_xcvr_in();
    test_pil_brk();
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Run time limit
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the tests did not complete", TIMEOUT_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* sim/clk_gen.sv */
/*
  Testbench clock and reset
  Free-running sysclk and an active-low reset held for a set number of cycles
*/
module clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 4
) (
  output logic sysclk,
  output logic s_twrf_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    sysclk = 1'b0;
    forever #(PERIOD_NS / 2) sysclk = ~sysclk;  // 50 percent duty
  end

  // Reset low from time zero, released on a rising edge
  initial begin
    s_twrf_n = 1'b0;
    repeat (RST_CYCLES) @(posedge sysclk);
    s_twrf_n <= 1'b1;
  end

endmodule

/* hdl/proc_sheet_top.sv */
/*
  Processor sheet top
  Holds the command decoder, transceiver pair, register file and ALU
  slice, bus sources are combined by OR as on the board
*/
module proc_sheet_top #(
  parameter int DATA_W = proc_pkg::data_w_default
) (
  input  logic              sysclk,
  input  logic              s_twrf_n,
  input  logic [63:0]       cs_bits,   // Microinstruction word
  input  logic              wrfstb,
  input  logic              term_n,
  input  logic              estof_n,
  input  logic              bedo_n,
  input  logic [DATA_W-1:0] idb_in,
  output logic [DATA_W-1:0] idb_out,
  output logic              acond_n,
  output logic              brk_n,
  output logic [3:0]        pil,
  output logic              lev0
);

  logic [DATA_W-1:0] idb;       // Internal bus
  logic [DATA_W-1:0] rd_data;
  logic [DATA_W-1:0] xcvr_in;
  logic [DATA_W-1:0] xcvr_out;
  logic [DATA_W-1:0] alu_res;
  logic [DATA_W-1:0] lit_word;  // Literal when selected, else zero
  logic              erf_n;
  logic              wrtrf;
  logic              ldacc;
  logic              lit_sel;

  assign lit_sel  = (cs_bits[proc_pkg::csidbs_lsb +: proc_pkg::csidbs_w] == proc_pkg::IDBS_LIT);
  assign lit_word = lit_sel ? DATA_W'(cs_bits[proc_pkg::lit_lsb +: proc_pkg::lit_w]) : '0;

  assign idb     = rd_data | xcvr_in | lit_word;  // Wired OR of all sources
  assign idb_out = rd_data | xcvr_out;

  proc_cmd_dec u_cmd_dec (
    .sysclk   (sysclk),
    .s_twrf_n (s_twrf_n),
    .cs_bits  (cs_bits),
    .idb2     (idb[2]),
    .erf_n    (erf_n),
    .wrtrf    (wrtrf),
    .ldacc    (ldacc),
    .brk_n    (brk_n),
    .pil      (pil),
    .lev0     (lev0)
  );

  proc_reg_file #(.DATA_W(DATA_W)) u_reg_file (
    .sysclk   (sysclk),
    .s_twrf_n (s_twrf_n),
    .cs_bits  (cs_bits),
    .erf_n    (erf_n),
    .wrtrf    (wrtrf),
    .wrfstb   (wrfstb),
    .term_n   (term_n),
    .wr_data  (alu_res),  // Register writes take the ALU result
    .rd_data  (rd_data)
  );

  proc_idb_xcvr #(.DATA_W(DATA_W)) u_idb_xcvr (
    .estof_n  (estof_n),
    .bedo_n   (bedo_n),
    .idb_in   (idb_in),
    .alu_res  (alu_res),
    .xcvr_in  (xcvr_in),
    .xcvr_out (xcvr_out)
  );

  proc_alu_slice #(.DATA_W(DATA_W)) u_alu_slice (
    .sysclk   (sysclk),
    .s_twrf_n (s_twrf_n),
    .cs_bits  (cs_bits),
    .ldacc    (ldacc),
    .idb      (idb),
    .alu_res  (alu_res),
    .acond_n  (acond_n)
  );

endmodule

/* hdl/proc_alu_slice.sv */
/*
  ALU slice with accumulator
  Stands in for the gate array, eight functions on the accumulator and
  the internal bus, accumulator load and a zero condition
*/
module proc_alu_slice #(
  parameter int DATA_W = 16
) (
  input  logic              sysclk,
  input  logic              s_twrf_n,
  input  logic [63:0]       cs_bits,
  input  logic              ldacc,    // Load accumulator from the result
  input  logic [DATA_W-1:0] idb,      // Internal bus, B operand
  output logic [DATA_W-1:0] alu_res,
  output logic              acond_n   // Low on zero result
);

  proc_pkg::alu_op_e op;
  logic [DATA_W-1:0] acc;  // A operand

  assign op = proc_pkg::alu_op_e'(cs_bits[proc_pkg::alu_op_lsb +: proc_pkg::alu_op_w]);

  // Function select, all results wrap at DATA_W
  always_comb begin
    case (op)
      proc_pkg::ALU_ADD: begin
        alu_res = acc + idb;
      end
      proc_pkg::ALU_SUB: begin
        alu_res = acc - idb;  // Accumulator minus bus
      end
      proc_pkg::ALU_AND: begin
        alu_res = acc & idb;
      end
      proc_pkg::ALU_OR: begin
        alu_res = acc | idb;
      end
      proc_pkg::ALU_XOR: begin
        alu_res = acc ^ idb;
      end
      proc_pkg::ALU_PASSB: begin
        alu_res = idb;
      end
      proc_pkg::ALU_INC: begin
        alu_res = idb + 1'b1;  // Increment of the bus, not the accumulator
      end
      proc_pkg::ALU_NOTB: begin
        alu_res = ~idb;
      end
      default: begin
        alu_res = idb;
      end
    endcase
  end

  // Accumulator
  always_ff @(posedge sysclk or negedge s_twrf_n) begin
    if (!s_twrf_n) begin
      acc <= '0;
    end else if (ldacc) begin
      acc <= alu_res;  // Seen by the next microword
    end
  end

  // Zero condition straight from the result
  assign acond_n = |alu_res;

endmodule

/* hdl/proc_idb_xcvr.sv */
/*
  IDB transceiver pair
  Couples the external IDB and the internal bus, one enable and one
  direction pick the driving side, the other side reads as zero
*/
module proc_idb_xcvr #(
  parameter int DATA_W = 16
) (
  input  logic              estof_n,  // Output enable, active low
  input  logic              bedo_n,   // Direction, low drives outward
  input  logic [DATA_W-1:0] idb_in,   // External IDB
  input  logic [DATA_W-1:0] alu_res,  // Internal side source
  output logic [DATA_W-1:0] xcvr_in,  // Toward the internal bus
  output logic [DATA_W-1:0] xcvr_out  // Toward the external IDB
);

  logic drive_in;
  logic drive_out;

  assign drive_in  = ~estof_n &  bedo_n;  // A to B
  assign drive_out = ~estof_n & ~bedo_n;  // B to A

  // Inbound half
  always_comb begin
    if (drive_in) begin
      xcvr_in = idb_in;
    end else begin
      xcvr_in = '0;
    end
  end

  // Outbound half
  always_comb begin
    if (drive_out) begin
      xcvr_out = alu_res;
    end else begin
      xcvr_out = '0;
    end
  end

endmodule

/* hdl/proc_reg_file.sv */
/*
  Register file, 1024 words
  Gated write of the ALU result and an enable-qualified read that reads
  as zero when idle, so it can be OR-ed onto the bus
*/
module proc_reg_file #(
  parameter int DATA_W = 16
) (
  input  logic              sysclk,
  input  logic              s_twrf_n,
  input  logic [63:0]       cs_bits,
  input  logic              erf_n,    // Chip select, active low
  input  logic              wrtrf,    // Decoder write command
  input  logic              wrfstb,   // Write strobe
  input  logic              term_n,   // Termination, high allows the write
  input  logic [DATA_W-1:0] wr_data,
  output logic [DATA_W-1:0] rd_data
);

  logic [DATA_W-1:0] regs [0:1023];
  logic [9:0]        addr;
  logic              wr_req;

  // Bank, B and A fields make up the word address
  assign addr = {cs_bits[proc_pkg::rf_lsb  +: proc_pkg::rf_w],
                 cs_bits[proc_pkg::lba_lsb +: proc_pkg::lba_w],
                 cs_bits[proc_pkg::laa_lsb +: proc_pkg::laa_w]};

  assign wr_req = wrtrf & wrfstb & term_n;  // Same term as TWRF on the board

  // Write port, held off while the sheet is in reset
  always_ff @(posedge sysclk) begin
    if (wr_req && s_twrf_n) begin
      regs[addr] <= wr_data;
    end
  end

  // Read port, asynchronous
  always_comb begin
    if (!erf_n && !wr_req) begin
      rd_data = regs[addr];
    end else begin
      rd_data = '0;  // Not driving the bus
    end
  end

endmodule

/* hdl/proc_cmd_dec.sv */
/*
  Command decoder
  Turns the cscomm and csidbs fields into register file and accumulator
  strobes, holds the PIL level and registers the conditional break
*/
module proc_cmd_dec (
  input  logic        sysclk,
  input  logic        s_twrf_n,
  input  logic [63:0] cs_bits,
  input  logic        idb2,     // Internal bus bit 2, break qualifier
  output logic        erf_n,    // Register file enable
  output logic        wrtrf,    // Register file write command
  output logic        ldacc,    // Accumulator load
  output logic        brk_n,
  output logic [3:0]  pil,
  output logic        lev0
);

  proc_pkg::cscomm_e comm;
  proc_pkg::csidbs_e idbs;
  logic [3:0]        pil_src;  // New level from literal low nibble
  logic              brk_hit;

  // Field extraction
  assign comm = proc_pkg::cscomm_e'(cs_bits[proc_pkg::cscomm_lsb +: proc_pkg::cscomm_w]);
  assign idbs = proc_pkg::csidbs_e'(cs_bits[proc_pkg::csidbs_lsb +: proc_pkg::csidbs_w]);

  // With IDBS_LIT the literal is what sits on the bus
  assign pil_src = cs_bits[proc_pkg::lit_lsb +: 4];

  // Combinational strobes, valid in the cycle of the microword
  always_comb begin
    wrtrf = 1'b0;
    ldacc = 1'b0;
    case (comm)
      proc_pkg::COMM_WRTRF: wrtrf = 1'b1;
      proc_pkg::COMM_LDACC: ldacc = 1'b1;
      default: ;  // No strobe
    endcase
  end

  // Enable for register reads and for writes, PAL fix for IDBS = REG
  assign erf_n = ~((idbs == proc_pkg::IDBS_REG) || wrtrf);

  assign brk_hit = (comm == proc_pkg::COMM_BRK) && idb2;

  // PIL level register
  always_ff @(posedge sysclk or negedge s_twrf_n) begin
    if (!s_twrf_n) begin
      pil <= 4'd0;
    end else if (comm == proc_pkg::COMM_SETPIL) begin
      pil <= pil_src;  // Visible one cycle later
    end
  end

  assign lev0 = (pil == 4'd0);  // Level zero follows the register

  // Break is low for the cycle after a qualified COMM_BRK
  always_ff @(posedge sysclk or negedge s_twrf_n) begin
    if (!s_twrf_n) begin
      brk_n <= 1'b1;
    end else begin
      brk_n <= ~brk_hit;
    end
  end

endmodule

/* hdl/proc_pkg.sv */
/*
  Processor sheet shared definitions
  Microcode field positions, data width default and opcode enums
*/
package proc_pkg;

  localparam int data_w_default = 16;  // IDB width

  // Microinstruction field positions, low bit and width
  localparam int laa_lsb     = 0;   // A register address
  localparam int laa_w       = 4;
  localparam int lba_lsb     = 4;   // B register address
  localparam int lba_w       = 4;
  localparam int rf_lsb      = 8;   // Register bank
  localparam int rf_w        = 2;
  localparam int alu_op_lsb  = 10;
  localparam int alu_op_w    = 3;
  localparam int lit_lsb     = 16;  // Literal word
  localparam int lit_w       = 16;
  localparam int cscomm_lsb  = 32;
  localparam int cscomm_w    = 5;
  localparam int csidbs_lsb  = 37;
  localparam int csidbs_w    = 5;
  localparam int csmis_lsb   = 42;  // Misc field, not decoded on this sheet
  localparam int csmis_w     = 2;

  // Microcode command
  typedef enum logic [4:0] {
    COMM_NOP    = 5'd0,
    COMM_WRTRF  = 5'd1,  // Write register file
    COMM_LDACC  = 5'd2,  // Load accumulator
    COMM_SETPIL = 5'd3,  // Load PIL level
    COMM_BRK    = 5'd4   // Conditional break on IDB2
  } cscomm_e;

  // Internal bus source
  typedef enum logic [4:0] {
    IDBS_NONE = 5'd0,
    IDBS_LIT  = 5'd1,  // Literal field
    IDBS_REG  = 5'd5   // Register file read
  } csidbs_e;

  // ALU function, B is the bus and A the accumulator
  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,
    ALU_SUB   = 3'd1,  // A minus B
    ALU_AND   = 3'd2,
    ALU_OR    = 3'd3,
    ALU_XOR   = 3'd4,
    ALU_PASSB = 3'd5,
    ALU_INC   = 3'd6,  // B plus one
    ALU_NOTB  = 3'd7
  } alu_op_e;

endpackage
